//--- logic/fetch_pkg.sv
package fetch_pkg;

    // Address and data path width
    localparam int xlen = 32;

    // First fetch address out of reset
    localparam logic [xlen-1:0] reset_pc = 32'h0000_1000;

    // BTB geometry
    localparam int btb_entries = 16;
    localparam int btb_index_bits = 4;

    // Index sits just above the halfword and byte bits
    localparam int btb_index_lsb = 2;
    localparam int btb_tag_lsb = btb_index_lsb + btb_index_bits;
    localparam int btb_tag_bits = xlen - btb_tag_lsb;

    // RAS geometry
    localparam int ras_depth = 8;
    localparam int ras_ptr_bits = $clog2(ras_depth);

    // Count must reach ras_depth itself
    localparam int ras_cnt_bits = $clog2(ras_depth + 1);

    // Next-PC source select
    typedef enum logic [1:0] {
        pc_sel_seq       = 2'b00,
        pc_sel_predicted = 2'b01,
        pc_sel_redirect  = 2'b10
    } pc_sel_e;

    // Branch resolution from EX
    typedef struct packed {
        pc_sel_e         sel;
        logic [xlen-1:0] target;
    } ex_redirect_t;

    // BTB training strobe from EX
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] target;
        logic            taken;
    } btb_update_t;

    // BTB lookup result for the current fetch PC
    typedef struct packed {
        logic            hit;
        logic            taken;
        logic [xlen-1:0] target;
    } btb_pred_t;

    // Top of the return address stack
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
    } ras_pred_t;

endpackage

//--- logic/btb.sv
`timescale 1ns/1ps

module btb (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [fetch_pkg::xlen-1:0] pc,
    input  fetch_pkg::btb_update_t     update,
    output fetch_pkg::btb_pred_t       pred
);
    import fetch_pkg::*;

    // Entry state
    // Only the valid bits are cleared by reset
    logic [btb_entries-1:0]  valid_q;
    logic [btb_tag_bits-1:0] tag_q    [btb_entries];
    logic [xlen-1:0]         target_q [btb_entries];
    logic [1:0]              cnt_q    [btb_entries];

    // Lookup side
    logic [btb_index_bits-1:0] rd_idx;
    logic [btb_tag_bits-1:0]   rd_tag;
    logic                      rd_hit;

    // Update side
    logic [btb_index_bits-1:0] wr_idx;
    logic [btb_tag_bits-1:0]   wr_tag;
    logic                      wr_match;
    logic [1:0]                cnt_next;

    // Split the fetch PC into index and tag
    assign rd_idx = pc[btb_tag_lsb-1:btb_index_lsb];
    assign rd_tag = pc[xlen-1:btb_tag_lsb];

    // Hit needs a live entry with the same tag
    assign rd_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

    // Lookup result in the same cycle as pc
    // Miss returns zeros so unwritten entries never leak out
    assign pred.hit    = rd_hit;
    assign pred.taken  = rd_hit && cnt_q[rd_idx][1];
    assign pred.target = rd_hit ? target_q[rd_idx] : '0;

    // Same split for the training PC
    assign wr_idx = update.pc[btb_tag_lsb-1:btb_index_lsb];
    assign wr_tag = update.pc[xlen-1:btb_tag_lsb];

    // Does the training PC already own its slot
    assign wr_match = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

    // Counter for the written entry
    always_comb begin
        if (wr_match) begin
            // Step toward the outcome, saturate at both ends
            if (update.taken) begin
                cnt_next = (cnt_q[wr_idx] == 2'd3) ? 2'd3 : cnt_q[wr_idx] + 2'd1;
            end else begin
                cnt_next = (cnt_q[wr_idx] == 2'd0) ? 2'd0 : cnt_q[wr_idx] - 2'd1;
            end
        end else begin
            // Fresh entry starts weakly biased toward the outcome
            cnt_next = update.taken ? 2'd2 : 2'd1;
        end
    end

    // Valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (update.valid) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Tag, target and counter arrays
    // Written at the edge so a lookup sees the change one cycle later
    always_ff @(posedge clk) begin
        if (update.valid) begin
            // Alias or empty slot gets replaced outright
            if (!wr_match) begin
                tag_q[wr_idx]    <= wr_tag;
                target_q[wr_idx] <= update.target;
            end
            cnt_q[wr_idx] <= cnt_next;
        end
    end

endmodule

//--- logic/ras.sv
`timescale 1ns/1ps

module ras (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  logic [fetch_pkg::xlen-1:0] push_addr,
    input  logic                       pop,
    input  logic                       stall,
    output fetch_pkg::ras_pred_t       top
);
    import fetch_pkg::*;

    // Circular storage of return addresses
    logic [xlen-1:0] stack_q [ras_depth];

    // Pointer to the current top entry
    logic [ras_ptr_bits-1:0] tos_q;

    // Number of live entries, saturates at ras_depth
    logic [ras_cnt_bits-1:0] cnt_q;

    logic                    empty;
    logic                    full;
    logic                    pop_eff;
    logic [ras_ptr_bits-1:0] wr_ptr;

    assign empty = (cnt_q == '0);
    assign full  = (cnt_q == ras_cnt_bits'(ras_depth));

    // Pop on an empty stack does nothing
    assign pop_eff = pop && !empty;

    // Push alone goes one slot up
    // Push with pop lands on the current top
    // Pointer wraps since the depth is a power of two
    assign wr_ptr = pop_eff ? tos_q : tos_q + 1'b1;

    // Pointer and count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tos_q <= '0;
            cnt_q <= '0;
        end else if (!stall) begin
            if (push && !pop_eff) begin
                tos_q <= tos_q + 1'b1;
                // Full stack drops its oldest entry, count stays put
                if (!full) begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end else if (pop_eff && !push) begin
                tos_q <= tos_q - 1'b1;
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (push && !stall) begin
            stack_q[wr_ptr] <= push_addr;
        end
    end

    // Prediction from the top entry
    assign top.valid  = !empty;
    assign top.target = empty ? '0 : stack_q[tos_q];

endmodule

//--- logic/pc_sel.sv
`timescale 1ns/1ps

module pc_sel #(
    parameter int ras_enable = 1,
    parameter int btb_enable = 1
) (
    // EX-stage resolution
    input  fetch_pkg::ex_redirect_t    ex_redirect,

    // ID-stage static prediction
    input  fetch_pkg::pc_sel_e         pc_sel_id,
    input  logic [fetch_pkg::xlen-1:0] pred_target_id,

    // RAS prediction and the ID return flag
    input  fetch_pkg::ras_pred_t       ras_top,
    input  logic                       is_jalr_id,

    // BTB prediction
    input  fetch_pkg::btb_pred_t       btb_pred,

    // Final select for the PC mux
    output fetch_pkg::pc_sel_e         pc_sel,
    output logic [fetch_pkg::xlen-1:0] pred_target,
    output logic                       btb_pred_taken,
    output logic                       ras_pop,

    // IF-side copies of the predictor results
    output fetch_pkg::btb_pred_t       btb_pred_if,
    output fetch_pkg::ras_pred_t       ras_pred_if
);
    import fetch_pkg::*;

    logic    ras_valid;
    logic    btb_valid;
    logic    id_pred;
    logic    ex_override;
    pc_sel_e sel_pred;

    // RAS counts only when ID confirms a return
    if (ras_enable != 0) begin : g_ras
        assign ras_valid   = ras_top.valid && is_jalr_id;
        assign ras_pred_if = ras_top;
    end else begin : g_no_ras
        assign ras_valid   = 1'b0;
        assign ras_pred_if = '0;
    end

    // BTB counts on a taken hit
    if (btb_enable != 0) begin : g_btb
        assign btb_valid   = btb_pred.hit && btb_pred.taken;
        assign btb_pred_if = btb_pred;
    end else begin : g_no_btb
        assign btb_valid   = 1'b0;
        assign btb_pred_if = '0;
    end

    // Decoded ID prediction outranks the speculative ones
    assign id_pred = (pc_sel_id == pc_sel_predicted);

    // Prediction arbitration: ID, then RAS, then BTB, then ID fallthrough
    always_comb begin
        if (id_pred) begin
            sel_pred    = pc_sel_id;
            pred_target = pred_target_id;
        end else if (ras_valid) begin
            sel_pred    = pc_sel_predicted;
            pred_target = ras_top.target;
        end else if (btb_valid) begin
            sel_pred    = pc_sel_predicted;
            pred_target = btb_pred.target;
        end else begin
            sel_pred    = pc_sel_id;
            pred_target = pred_target_id;
        end
    end

    // Flags a RAS or BTB win, seen even under an EX override
    assign btb_pred_taken = !id_pred && (ras_valid || btb_valid);

    // EX redirect beats every prediction
    assign ex_override = (ex_redirect.sel == pc_sel_redirect);
    assign pc_sel      = ex_override ? pc_sel_redirect : sel_pred;

    // Consume the return address only when it steers fetch
    assign ras_pop = !id_pred && ras_valid && !ex_override;

endmodule

//--- logic/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       stall,

    // Source select from the arbiter
    input  fetch_pkg::pc_sel_e         pc_sel,

    // Predicted target for pc_sel_predicted
    input  logic [fetch_pkg::xlen-1:0] pred_target,

    // EX target for pc_sel_redirect
    input  logic [fetch_pkg::xlen-1:0] redirect_target,

    // Current fetch address
    output logic [fetch_pkg::xlen-1:0] pc
);
    import fetch_pkg::*;

    logic [xlen-1:0] pc_seq;
    logic [xlen-1:0] pc_next;

    // Fall-through address
    assign pc_seq = pc + xlen'(4);

    // Three-way next-PC mux
    always_comb begin
        case (pc_sel)
            pc_sel_redirect: begin
                pc_next = redirect_target;
            end
            pc_sel_predicted: begin
                pc_next = pred_target;
            end
            default: begin
                pc_next = pc_seq;
            end
        endcase
    end

    // Fetch PC register
    // Stall freezes fetch in place
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

endmodule

//--- logic/fetch_pc_unit.sv
`timescale 1ns/1ps

module fetch_pc_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       stall,

    // EX stage
    input  fetch_pkg::ex_redirect_t    ex_redirect,
    input  fetch_pkg::btb_update_t     btb_update,

    // ID stage
    input  fetch_pkg::pc_sel_e         pc_sel_id,
    input  logic [fetch_pkg::xlen-1:0] pred_target_id,
    input  logic                       is_jalr_id,
    input  logic                       ras_push,
    input  logic [fetch_pkg::xlen-1:0] ras_push_addr,

    // Fetch side
    output logic [fetch_pkg::xlen-1:0] pc,
    output fetch_pkg::pc_sel_e         pc_sel,
    output logic [fetch_pkg::xlen-1:0] pred_target,
    output logic                       btb_pred_taken,
    output fetch_pkg::btb_pred_t       btb_pred_if,
    output fetch_pkg::ras_pred_t       ras_pred_if
);
    import fetch_pkg::*;

    // Predictor results into the arbiter
    btb_pred_t btb_pred;
    ras_pred_t ras_top;

    // Arbiter pops the RAS on a winning return
    logic ras_pop;

    // PC register and next-PC mux
    pc_gen u_pc_gen (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall           (stall),
        .pc_sel          (pc_sel),
        .pred_target     (pred_target),
        .redirect_target (ex_redirect.target),
        .pc              (pc)
    );

    // Branch target buffer, looked up with the current pc
    btb u_btb (
        .clk    (clk),
        .rst_n  (rst_n),
        .pc     (pc),
        .update (btb_update),
        .pred   (btb_pred)
    );

    // Return address stack
    ras u_ras (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (ras_push),
        .push_addr (ras_push_addr),
        .pop       (ras_pop),
        .stall     (stall),
        .top       (ras_top)
    );

    // Both predictors switched on
    pc_sel #(
        .ras_enable (1),
        .btb_enable (1)
    ) u_pc_sel (
        .ex_redirect    (ex_redirect),
        .pc_sel_id      (pc_sel_id),
        .pred_target_id (pred_target_id),
        .ras_top        (ras_top),
        .is_jalr_id     (is_jalr_id),
        .btb_pred       (btb_pred),
        .pc_sel         (pc_sel),
        .pred_target    (pred_target),
        .btb_pred_taken (btb_pred_taken),
        .ras_pop        (ras_pop),
        .btb_pred_if    (btb_pred_if),
        .ras_pred_if    (ras_pred_if)
    );

endmodule

//--- tests/fetch_pc_unit_tb.sv
`timescale 1ns/1ps

module fetch_pc_unit_tb;
    import fetch_pkg::*;

    // Run length in clock cycles
    localparam int reset_cycles    = 8;
    localparam int directed_cycles = 80;
    localparam int random_cycles   = 2000;
    localparam int total_cycles    = reset_cycles + directed_cycles + random_cycles;

    // Drive just after the edge, sample just before the next one
    localparam int drive_delay  = 1;
    localparam int sample_delay = 7;

    // Expected arbitration outcome
    typedef struct packed {
        pc_sel_e         sel;
        logic [xlen-1:0] target;
        logic            taken;
        logic            pop;
    } arb_t;

    logic            clk;
    logic            rst_n;
    logic            stall;
    ex_redirect_t    ex_redirect;
    btb_update_t     btb_update;
    pc_sel_e         pc_sel_id;
    logic [xlen-1:0] pred_target_id;
    logic            is_jalr_id;
    logic            ras_push;
    logic [xlen-1:0] ras_push_addr;
    logic [xlen-1:0] pc;
    pc_sel_e         pc_sel;
    logic [xlen-1:0] pred_target;
    logic            btb_pred_taken;
    btb_pred_t       btb_pred_if;
    ras_pred_t       ras_pred_if;

    // Reference BTB indexed by pc[5:2] with tag pc[31:6]
    logic [xlen-1:0] m_pc;
    logic            m_valid  [btb_entries];
    logic [25:0]     m_tag    [btb_entries];
    logic [xlen-1:0] m_target [btb_entries];
    logic [1:0]      m_cnt    [btb_entries];

    // Return stack queue with the newest entry at the back
    logic [xlen-1:0] m_stack [$];

    fetch_pc_unit DUT (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_pc(string name, logic [xlen-1:0] got, logic [xlen-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_sel(string name, pc_sel_e got, pc_sel_e exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_btb(string name, btb_pred_t got, btb_pred_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_ras(string name, ras_pred_t got, ras_pred_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    // Lookup returns all zeros on a miss
    function automatic btb_pred_t predict_btb(logic [xlen-1:0] addr);
        btb_pred_t p;
        int        i;
        i        = int'(addr[5:2]);
        p.hit    = m_valid[i] && (m_tag[i] == addr[31:6]);
        p.taken  = p.hit && m_cnt[i][1];
        p.target = p.hit ? m_target[i] : '0;
        return p;
    endfunction

    function automatic ras_pred_t predict_ras();
        ras_pred_t r;
        r = '0;
        if (m_stack.size() != 0) begin
            r.valid  = 1'b1;
            r.target = m_stack[m_stack.size() - 1];
        end
        return r;
    endfunction

    // EX first, then ID, RAS, BTB, then ID fallthrough
    function automatic arb_t arbitrate();
        arb_t      a;
        btb_pred_t b;
        ras_pred_t r;
        logic      id_win;
        logic      ras_win;
        logic      btb_win;
        b        = predict_btb(m_pc);
        r        = predict_ras();
        id_win   = (pc_sel_id == pc_sel_predicted);
        ras_win  = r.valid && is_jalr_id;
        btb_win  = b.hit && b.taken;
        a.sel    = pc_sel_id;
        a.target = pred_target_id;
        if (!id_win && ras_win) begin
            a.sel    = pc_sel_predicted;
            a.target = r.target;
        end else if (!id_win && btb_win) begin
            a.sel    = pc_sel_predicted;
            a.target = b.target;
        end
        a.taken = !id_win && (ras_win || btb_win);
        a.pop   = !id_win && ras_win && (ex_redirect.sel != pc_sel_redirect);
        if (ex_redirect.sel == pc_sel_redirect) begin
            a.sel = pc_sel_redirect;
        end
        return a;
    endfunction

    function automatic logic [xlen-1:0] next_fetch_pc(arb_t a);
        logic [xlen-1:0] nxt;
        case (a.sel)
            pc_sel_redirect:  nxt = ex_redirect.target;
            pc_sel_predicted: nxt = a.target;
            default:          nxt = m_pc + 32'd4;
        endcase
        return nxt;
    endfunction

    task automatic reset_model();
        int i;
        m_pc = reset_pc;
        m_stack.delete();
        for (i = 0; i < btb_entries; i++) begin
            m_valid[i] = 1'b0;
        end
    endtask

    // One clock edge of the reference
    task automatic advance_model();
        arb_t a;
        int   i;
        a = arbitrate();
        // Training still applies under stall
        if (btb_update.valid) begin
            i = int'(btb_update.pc[5:2]);
            if (m_valid[i] && (m_tag[i] == btb_update.pc[31:6])) begin
                if (btb_update.taken && m_cnt[i] != 2'd3) begin
                    m_cnt[i] = m_cnt[i] + 2'd1;
                end else if (!btb_update.taken && m_cnt[i] != 2'd0) begin
                    m_cnt[i] = m_cnt[i] - 2'd1;
                end
            end else begin
                m_valid[i]  = 1'b1;
                m_tag[i]    = btb_update.pc[31:6];
                m_target[i] = btb_update.target;
                m_cnt[i]    = btb_update.taken ? 2'd2 : 2'd1;
            end
        end
        if (!stall) begin
            m_pc = next_fetch_pc(a);
            // Push with pop swaps the top, full stack drops its oldest
            if (a.pop && ras_push) begin
                m_stack[m_stack.size() - 1] = ras_push_addr;
            end else if (a.pop) begin
                void'(m_stack.pop_back());
            end else if (ras_push) begin
                m_stack.push_back(ras_push_addr);
                if (m_stack.size() > ras_depth) begin
                    void'(m_stack.pop_front());
                end
            end
        end
    endtask

    task automatic compare_outputs();
        arb_t a;
        a = arbitrate();
        check_pc("pc", pc, m_pc);
        check_sel("pc_sel", pc_sel, a.sel);
        check_pc("pred_target", pred_target, a.target);
        check_flag("btb_pred_taken", btb_pred_taken, a.taken);
        check_btb("btb_pred_if", btb_pred_if, predict_btb(m_pc));
        check_ras("ras_pred_if", ras_pred_if, predict_ras());
    endtask

    // Model steps on the edge, outputs checked just before the next
    initial begin
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                reset_model();
            end else begin
                advance_model();
            end
            #(sample_delay);
            if (rst_n) begin
                compare_outputs();
            end
        end
    end

    initial begin
        #(40 * total_cycles);
        abort_run("watchdog timeout: stimulus did not finish in time");
    end

    task automatic next_cycle();
        @(posedge clk);
        #(drive_delay);
    endtask

    task automatic idle_inputs();
        stall          = 1'b0;
        ex_redirect    = '0;
        btb_update     = '0;
        pc_sel_id      = pc_sel_seq;
        pred_target_id = '0;
        is_jalr_id     = 1'b0;
        ras_push       = 1'b0;
        ras_push_addr  = '0;
    endtask

    task automatic set_redirect(logic [xlen-1:0] target);
        ex_redirect.sel    = pc_sel_redirect;
        ex_redirect.target = target;
    endtask

    task automatic train_btb(logic [xlen-1:0] at, logic [xlen-1:0] target, logic taken);
        btb_update.valid  = 1'b1;
        btb_update.pc     = at;
        btb_update.target = target;
        btb_update.taken  = taken;
    endtask

    // Word aligned address in a small window so tags collide often
    function automatic logic [xlen-1:0] rand_addr();
        return 32'h0000_1000 | ($urandom() & 32'h0000_03fc);
    endfunction

    initial begin : stimulus
        int k;
        void'($urandom(32'hec2e6b1b));
        rst_n    = 1'b0;
        idle_inputs();
        repeat (reset_cycles) next_cycle();
        rst_n = 1'b1;

        // Sequential fetch from the reset address, then a stall
        #(sample_delay - drive_delay);
        check_pc("pc", pc, reset_pc);
        check_sel("pc_sel", pc_sel, pc_sel_seq);
        repeat (4) next_cycle();
        stall = 1'b1;
        repeat (3) next_cycle();
        stall = 1'b0;

        // Park at 0x2000 with one call and a taken BTB entry
        next_cycle();
        set_redirect(32'h0000_2000);
        ras_push      = 1'b1;
        ras_push_addr = 32'h0000_5000;
        next_cycle();
        idle_inputs();
        stall = 1'b1;
        train_btb(32'h0000_2000, 32'h0000_3000, 1'b1);

        // EX beats RAS and BTB, flag still up, nothing popped
        next_cycle();
        idle_inputs();
        set_redirect(32'h0000_2000);
        is_jalr_id = 1'b1;

        // EX beats ID as well
        next_cycle();
        set_redirect(32'h0000_6000);
        pc_sel_id      = pc_sel_predicted;
        pred_target_id = 32'h0000_7000;

        // Back to 0x2000, ID beats RAS and BTB
        next_cycle();
        idle_inputs();
        set_redirect(32'h0000_2000);
        next_cycle();
        idle_inputs();
        pc_sel_id      = pc_sel_predicted;
        pred_target_id = 32'h0000_7100;
        is_jalr_id     = 1'b1;

        // Ten calls overflow the stack, ten returns drain it past empty
        for (k = 0; k < 10; k++) begin
            next_cycle();
            idle_inputs();
            ras_push      = 1'b1;
            ras_push_addr = 32'h0001_0000 + 32'(k << 4);
        end
        for (k = 0; k < 10; k++) begin
            next_cycle();
            idle_inputs();
            is_jalr_id = 1'b1;
        end

        // Park on slot 6 and walk its counter to both ends
        next_cycle();
        idle_inputs();
        set_redirect(32'h0000_3018);
        next_cycle();
        idle_inputs();
        stall = 1'b1;
        train_btb(32'h0000_3018, 32'h0000_3500, 1'b1);
        repeat (2) begin
            next_cycle();
            train_btb(32'h0000_3018, 32'h0000_3500, 1'b1);
        end
        repeat (4) begin
            next_cycle();
            train_btb(32'h0000_3018, 32'h0000_3500, 1'b0);
        end

        // Alias with another tag takes over the slot
        next_cycle();
        train_btb(32'h0000_4018, 32'h0000_3600, 1'b1);
        next_cycle();
        train_btb(32'h0000_3020, 32'h0000_3700, 1'b0);
        next_cycle();
        idle_inputs();
        set_redirect(32'h0000_4018);

        // Taken alias is overridden on the way to the not-taken entry
        next_cycle();
        idle_inputs();
        set_redirect(32'h0000_3020);

        // Fresh not-taken entry hits without predicting, one taken step flips it
        next_cycle();
        idle_inputs();
        stall = 1'b1;
        train_btb(32'h0000_3020, 32'h0000_3700, 1'b1);
        next_cycle();
        idle_inputs();

        // Random mix of every input kind
        for (k = 0; k < random_cycles; k++) begin
            next_cycle();
            stall              = ($urandom_range(7) == 0);
            ex_redirect.sel    = ($urandom_range(9) == 0) ? pc_sel_redirect : pc_sel_seq;
            ex_redirect.target = rand_addr();
            pc_sel_id          = ($urandom_range(9) == 0) ? pc_sel_predicted : pc_sel_seq;
            pred_target_id     = rand_addr();
            is_jalr_id         = ($urandom_range(5) == 0);
            ras_push           = ($urandom_range(4) == 0);
            ras_push_addr      = rand_addr();
            btb_update.valid   = ($urandom_range(2) == 0);
            btb_update.pc      = ($urandom_range(1) == 0) ? m_pc : rand_addr();
            btb_update.target  = rand_addr();
            btb_update.taken   = ($urandom_range(3) != 0);
        end

        next_cycle();
        idle_inputs();
        repeat (2) next_cycle();
        // Past the last sample
        #(sample_delay);
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- filelist.f
logic/fetch_pkg.sv
logic/btb.sv
logic/ras.sv
logic/pc_sel.sv
logic/pc_gen.sv
logic/fetch_pc_unit.sv
tests/fetch_pc_unit_tb.sv

//--- Makefile
VERILATOR := verilator
TOP       := fetch_pc_unit_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
FLAGS     := --binary --timing -Wno-fatal
LINT      := --lint-only --timing

.PHONY: all build run lint clean

# Build and run, the exit status reports pass or fail
all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
